// ==== all.f ====
+incdir+hw
hw/uart_pkg.sv
hw/baud_tick_gen.sv
hw/rs232_rx.sv
hw/rs232_tx.sv
hw/byte_fifo.sv
hw/uart_axil_regs.sv
hw/uart_axil_top.sv
bench/uart_checker.sv
bench/uart_tb.sv

// ==== bench/uart_checker.sv ====
/* UART scoreboard
   decodes txd frames and checks AXI read and write responses */
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uart_checker (
  input  logic                ref_clk,
  input  logic                reset,
  input  logic                txd,
  input  logic                awready,
  input  logic                wready,
  input  logic                bvalid,
  input  logic                bready,
  input  uart_pkg::axi_resp_t bresp,
  input  logic                arready,
  input  logic                rvalid,
  input  logic                rready,
  input  logic [31:0]         rdata,
  input  uart_pkg::axi_resp_t rresp,
  output int                  err_cnt
);
  import uart_pkg::*;

  localparam int BIT_CYC = `UART_CLK_DIV * (1 << `UART_OVS_LOG2);

  logic [7:0]  exp_tx [$];
  logic [31:0] exp_rdata [$];
  logic [31:0] exp_rmask [$];   // zero bits are don't care
  axi_resp_t   exp_rresp [$];
  axi_resp_t   exp_bresp [$];
  logic [7:0]  tx_got;
  logic        stop_got;

  initial err_cnt = 0;

  task automatic expect_tx(input logic [7:0] b);
    exp_tx.push_back(b);
  endtask

  task automatic expect_read(input logic [31:0] d, input logic [31:0] m, input axi_resp_t r);
    exp_rdata.push_back(d);
    exp_rmask.push_back(m);
    exp_rresp.push_back(r);
  endtask

  task automatic expect_write(input axi_resp_t r);
    exp_bresp.push_back(r);
  endtask

  function automatic int tx_pending();
    return exp_tx.size();
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] got_v);
    $display("Mismatch %s exp=%h got=%h", name, exp_v, got_v);
    err_cnt++;
  endtask

  task automatic report_error(input string msg);
    $display("Error: %s", msg);
    err_cnt++;
  endtask

  // ##################################################
  // serial side
  initial begin
    @(negedge reset);
    @(posedge ref_clk);
    if (txd !== 1'b0) report_mismatch("txd", 32'h0, {31'd0, txd});   // idle level
  end

  initial begin
    forever begin
      @(posedge txd);                                      // start edge
      repeat (BIT_CYC / 2) @(posedge ref_clk);
      if (txd !== 1'b1) report_error("start bit on txd did not last to mid-bit");
      for (int i = 0; i < 8; i++) begin
        repeat (BIT_CYC) @(posedge ref_clk);
        tx_got[i] = ~txd;                                  // inverted, lsb first
      end
      repeat (BIT_CYC) @(posedge ref_clk);
      stop_got = txd;
      if (stop_got !== 1'b0) report_mismatch("txd_stop", 32'h0, {31'd0, stop_got});
      if (exp_tx.size() == 0) begin
        report_error("frame seen on txd with no byte pending");
      end else begin
        if (tx_got !== exp_tx[0]) report_mismatch("txd_data", exp_tx[0], tx_got);
        exp_tx.delete(0);
      end
    end
  end

  // ##################################################
  // bus side
  always @(posedge ref_clk) begin
    if (!reset && (wready !== awready))
      report_mismatch("wready", {31'd0, awready}, {31'd0, wready});   // pulse together
    if (!reset && bvalid && awready) report_error("write accepted while bvalid pending");
    if (!reset && rvalid && arready) report_error("read accepted while rvalid pending");
    if (!reset && bvalid && bready) begin
      if (exp_bresp.size() == 0) begin
        report_error("write response with no write outstanding");
      end else begin
        if (bresp !== exp_bresp[0]) report_mismatch("bresp", exp_bresp[0], bresp);
        exp_bresp.delete(0);
      end
    end
    if (!reset && rvalid && rready) begin
      if (exp_rdata.size() == 0) begin
        report_error("read response with no read outstanding");
      end else begin
        if ((rdata & exp_rmask[0]) !== (exp_rdata[0] & exp_rmask[0]))
          report_mismatch("rdata", exp_rdata[0], rdata);
        if (rresp !== exp_rresp[0]) report_mismatch("rresp", exp_rresp[0], rresp);
        exp_rdata.delete(0);
        exp_rmask.delete(0);
        exp_rresp.delete(0);
      end
    end
  end

endmodule

// ==== bench/uart_tb.sv ====
/* UART testbench
   table-driven AXI4-Lite and serial stimulus around the AXI UART */
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uart_tb;
  import uart_pkg::*;

  localparam int CLK_NS   = 10;
  localparam int BIT_CYC  = `UART_CLK_DIV * (1 << `UART_OVS_LOG2);
  localparam int FRAME_NS = 10 * BIT_CYC * CLK_NS;
  localparam int WAIT_MAX = 64;     // handshake bound in cycles
  localparam int HOLD_CYC = 6;      // cycles of held bready/rready

  localparam logic [3:0] K_RD_STAT = 4'd0;
  localparam logic [3:0] K_RD_DATA = 4'd1;
  localparam logic [3:0] K_RD_HOLD = 4'd2;
  localparam logic [3:0] K_RD_BAD  = 4'd3;
  localparam logic [3:0] K_WR_DATA = 4'd4;
  localparam logic [3:0] K_WR_HOLD = 4'd5;
  localparam logic [3:0] K_WR_BAD  = 4'd6;
  localparam logic [3:0] K_RX      = 4'd7;
  localparam logic [3:0] K_DRAIN   = 4'd8;
  localparam logic [3:0] K_RAND    = 4'd9;

  typedef struct packed {
    logic [3:0] kind;
    logic [7:0] val;
    logic       stop;   // rx stop level, or expected frame_err
    axi_resp_t  resp;
  } step_t;

  logic        ref_clk;
  logic        reset;
  logic [3:0]  awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic        wvalid;
  logic        wready;
  axi_resp_t   bresp;
  logic        bvalid;
  logic        bready;
  logic [3:0]  araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  axi_resp_t   rresp;
  logic        rvalid;
  logic        rready;
  logic        rxd;
  logic        txd;

  step_t steps [$];
  int    seed = 32'hcfb9;
  int    bench_err;
  int    chk_err;
  logic  table_ready;

  uart_axil_top u_uart_axil_top (.*);

  uart_checker u_checker (
    .ref_clk, .reset, .txd, .awready, .wready, .bvalid, .bready, .bresp,
    .arready, .rvalid, .rready, .rdata, .rresp, .err_cnt(chk_err)
  );

  always #(CLK_NS / 2) ref_clk = ~ref_clk;

  task automatic next_cycle();
    @(posedge ref_clk);
    #1;
  endtask

  task automatic add_step(input logic [3:0] kind, input logic [7:0] val, input logic stop,
                          input axi_resp_t resp);
    steps.push_back(step_t'{kind, val, stop, resp});
  endtask

  // ##################################################
  // bus and line drivers
  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data, input int hold);
    int n;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    n = 0;
    next_cycle();
    while (!awready && n < WAIT_MAX) begin
      next_cycle();
      n++;
    end
    if (!awready) begin
      $display("Error: awready never came for write to %h", addr);
      bench_err++;
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
    n = 0;
    while (!bvalid && n < WAIT_MAX) begin
      next_cycle();
      n++;
    end
    if (!bvalid) begin
      $display("Error: bvalid never came for write to %h", addr);
      bench_err++;
    end
    if (hold > 0) begin
      awvalid = 1'b1;             // next write offered behind the held response
      wvalid  = 1'b1;
    end
    repeat (hold) next_cycle();   // response left pending
    bready = 1'b1;
    next_cycle();
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [3:0] addr, input int hold, output logic [31:0] data);
    int n;
    araddr  = addr;
    arvalid = 1'b1;
    n = 0;
    next_cycle();
    while (!arready && n < WAIT_MAX) begin
      next_cycle();
      n++;
    end
    if (!arready) begin
      $display("Error: arready never came for read of %h", addr);
      bench_err++;
    end
    arvalid = 1'b0;
    n = 0;
    while (!rvalid && n < WAIT_MAX) begin
      next_cycle();
      n++;
    end
    if (!rvalid) begin
      $display("Error: rvalid never came for read of %h", addr);
      bench_err++;
    end
    data = rdata;
    if (hold > 0) arvalid = 1'b1;   // next read offered behind the held data
    repeat (hold) next_cycle();
    rready = 1'b1;
    next_cycle();
    rready = 1'b0;
  endtask

  task automatic drive_bit(input logic v);
    rxd = v;
    repeat (BIT_CYC) @(posedge ref_clk);
    #1;
  endtask

  task automatic send_frame(input logic [7:0] b, input logic stop);
    drive_bit(1'b1);                                 // start is high
    for (int i = 0; i < 8; i++) drive_bit(~b[i]);
    drive_bit(stop);
    drive_bit(1'b0);                                 // idle gap
    drive_bit(1'b0);
  endtask

  // waits for all expected frames, then for tx busy to drop
  task automatic drain_tx();
    logic [31:0] d;
    while (u_checker.tx_pending() != 0) next_cycle();
    d = 32'h8;
    while (d[3]) begin
      u_checker.expect_read(32'h0, 32'h0, RESP_OKAY);
      axi_read(`UART_ADDR_STAT, 0, d);
    end
  endtask

  task automatic run_step(input step_t s);
    logic [31:0] d;
    logic [7:0]  r;
    case (s.kind)
      K_RD_STAT: begin
        u_checker.expect_read({24'd0, s.val}, '1, s.resp);
        axi_read(`UART_ADDR_STAT, 0, d);
      end
      K_RD_DATA: begin
        u_checker.expect_read({23'd0, s.stop, s.val}, '1, s.resp);
        axi_read(`UART_ADDR_DATA, 0, d);
      end
      K_RD_HOLD: begin
        u_checker.expect_read({23'd0, s.stop, s.val}, '1, s.resp);
        u_checker.expect_read(32'h0, '1, RESP_SLVERR);   // rx FIFO emptied by the first read
        axi_read(`UART_ADDR_DATA, HOLD_CYC, d);
        axi_read(`UART_ADDR_DATA, 0, d);                 // the stalled read
      end
      K_RD_BAD: begin
        u_checker.expect_read(32'h0, '1, s.resp);
        axi_read(4'hc, 0, d);
      end
      K_WR_DATA: begin
        u_checker.expect_write(s.resp);
        if (s.resp == RESP_OKAY) u_checker.expect_tx(s.val);
        axi_write(`UART_ADDR_DATA, {24'd0, s.val}, 0);
      end
      K_WR_HOLD: begin
        repeat (2) begin
          u_checker.expect_write(s.resp);
          if (s.resp == RESP_OKAY) u_checker.expect_tx(s.val);
        end
        axi_write(`UART_ADDR_DATA, {24'd0, s.val}, HOLD_CYC);
        axi_write(`UART_ADDR_DATA, {24'd0, s.val}, 0);   // the stalled write
      end
      K_WR_BAD: begin
        u_checker.expect_write(s.resp);
        axi_write(4'h8, {24'd0, s.val}, 0);
      end
      K_RX: send_frame(s.val, s.stop);
      K_DRAIN: drain_tx();
      K_RAND: begin
        r = 8'($random(seed));
        u_checker.expect_write(RESP_OKAY);
        u_checker.expect_tx(r);
        axi_write(`UART_ADDR_DATA, {24'd0, r}, 0);
        send_frame(r, 1'b0);
        u_checker.expect_read({24'd0, r}, '1, RESP_OKAY);
        axi_read(`UART_ADDR_DATA, 0, d);
      end
      default: begin
        $display("Error: unknown step kind %0d", s.kind);
        bench_err++;
      end
    endcase
  endtask

  task automatic build_table();
    add_step(K_RD_STAT, 8'h00, 1'b0, RESP_OKAY);       // reset state
    add_step(K_RD_DATA, 8'h00, 1'b0, RESP_SLVERR);
    add_step(K_RD_BAD,  8'h00, 1'b0, RESP_SLVERR);
    add_step(K_WR_BAD,  8'h5a, 1'b0, RESP_SLVERR);
    add_step(K_WR_DATA, 8'h55, 1'b0, RESP_OKAY);       // transmit
    add_step(K_WR_DATA, 8'h0f, 1'b0, RESP_OKAY);
    add_step(K_RD_STAT, 8'h08, 1'b0, RESP_OKAY);
    add_step(K_DRAIN,   8'h00, 1'b0, RESP_OKAY);
    add_step(K_RD_STAT, 8'h00, 1'b0, RESP_OKAY);
    add_step(K_RX,      8'ha5, 1'b0, RESP_OKAY);       // receive in order
    add_step(K_RD_STAT, 8'h01, 1'b0, RESP_OKAY);
    add_step(K_RX,      8'h3c, 1'b0, RESP_OKAY);
    add_step(K_RD_DATA, 8'ha5, 1'b0, RESP_OKAY);
    add_step(K_RD_DATA, 8'h3c, 1'b0, RESP_OKAY);
    add_step(K_RD_STAT, 8'h00, 1'b0, RESP_OKAY);
    add_step(K_RX,      8'h81, 1'b1, RESP_OKAY);       // framing error
    add_step(K_RD_DATA, 8'h81, 1'b1, RESP_OKAY);
    for (int i = 1; i <= 5; i++) add_step(K_RX, 8'(i * 17), 1'b0, RESP_OKAY);
    add_step(K_RD_STAT, 8'h05, 1'b0, RESP_OKAY);       // overrun
    for (int i = 1; i <= 4; i++) add_step(K_RD_DATA, 8'(i * 17), 1'b0, RESP_OKAY);
    add_step(K_RD_STAT, 8'h00, 1'b0, RESP_OKAY);
    for (int i = 1; i <= 5; i++) add_step(K_WR_DATA, 8'(i), 1'b0, RESP_OKAY);
    add_step(K_WR_DATA, 8'h06, 1'b0, RESP_SLVERR);     // tx FIFO full
    add_step(K_RD_STAT, 8'h0a, 1'b0, RESP_OKAY);
    add_step(K_DRAIN,   8'h00, 1'b0, RESP_OKAY);
    add_step(K_WR_HOLD, 8'h77, 1'b0, RESP_OKAY);       // back-pressure
    add_step(K_RX,      8'h99, 1'b0, RESP_OKAY);
    add_step(K_RD_HOLD, 8'h99, 1'b0, RESP_OKAY);
    add_step(K_DRAIN,   8'h00, 1'b0, RESP_OKAY);
    for (int i = 0; i < 3; i++) add_step(K_RAND, 8'h00, 1'b0, RESP_OKAY);
    add_step(K_DRAIN,   8'h00, 1'b0, RESP_OKAY);
    add_step(K_RD_STAT, 8'h00, 1'b0, RESP_OKAY);
  endtask

  // ##################################################
  // main sequence
  initial begin
    ref_clk     = 1'b0;
    reset       = 1'b1;
    awaddr      = '0;
    awvalid     = 1'b0;
    wdata       = '0;
    wvalid      = 1'b0;
    bready      = 1'b0;
    araddr      = '0;
    arvalid     = 1'b0;
    rready      = 1'b0;
    rxd         = 1'b0;
    bench_err   = 0;
    table_ready = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (3) @(posedge ref_clk);
    #1 reset = 1'b0;
    repeat (2) next_cycle();
    foreach (steps[i]) run_step(steps[i]);
    if (u_checker.tx_pending() != 0) begin
      $display("Error: %0d bytes never appeared on txd", u_checker.tx_pending());
      bench_err++;
    end
    $display("errors: checker %0d, bench %0d", chk_err, bench_err);
    if (chk_err == 0 && bench_err == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

  // watchdog, 12 frame times per table entry
  initial begin
    wait (table_ready);
    #(steps.size() * 12 * FRAME_NS);
    $display("Error: run timed out after %0d frame times", steps.size() * 12);
    $display("errors: checker %0d, bench %0d", chk_err, bench_err + 1);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== hw/baud_tick_gen.sv ====
/* Baud tick generator
   one-cycle sampling enable at 8x the bit rate */
`timescale 1ns/10ps
`include "uart_cfg.svh"

module baud_tick_gen (
  input  logic ref_clk,
  input  logic reset,
  output logic samp_tick
);

  localparam int CNT_W = (`UART_CLK_DIV > 1) ? $clog2(`UART_CLK_DIV) : 1;

  logic [CNT_W-1:0] div_cnt;

  always_ff @(posedge ref_clk) begin
    if (reset) begin
      div_cnt   <= '0;
      samp_tick <= 1'b0;
    end else if (div_cnt == CNT_W'(`UART_CLK_DIV - 1)) begin
      div_cnt   <= '0;       // terminal count
      samp_tick <= 1'b1;
    end else begin
      div_cnt   <= div_cnt + 1'b1;
      samp_tick <= 1'b0;
    end
  end

  generate
    if (`UART_CLK_DIV > 1) begin : g_tick_chk
      a_tick_single: assert property (@(posedge ref_clk) disable iff (reset)
        samp_tick |=> !samp_tick);
    end
  endgenerate

endmodule

// ==== hw/byte_fifo.sv ====
/* Synchronous FIFO
   circular buffer for any entry type, head always on dout */
`timescale 1ns/10ps

module byte_fifo #(
  parameter type entry_t = logic [7:0],
  parameter int  DEPTH   = 4
) (
  input  logic   ref_clk,
  input  logic   reset,
  input  logic   push,
  input  entry_t din,
  output logic   full,
  input  logic   pop,
  output entry_t dout,
  output logic   empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  entry_t           mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign full    = (count == CNT_W'(DEPTH));
  assign empty   = (count == '0);
  assign dout    = mem[rd_ptr];   // show-ahead

  always_ff @(posedge ref_clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge ref_clk) begin
    if (do_push) mem[wr_ptr] <= din;
  end

  a_no_overflow: assert property (@(posedge ref_clk) disable iff (reset)
    push |-> !full);
  a_no_underflow: assert property (@(posedge ref_clk) disable iff (reset)
    pop |-> !empty);

endmodule

// ==== hw/rs232_rx.sv ====
/* RS232 receiver
   oversampled start/data/stop FSM, line idles low, data inverted */
`timescale 1ns/10ps
`include "uart_cfg.svh"

module rs232_rx (
  input  logic       ref_clk,
  input  logic       reset,
  input  logic       samp_tick,
  input  logic       rxd,
  output logic [7:0] rx_data,
  output logic       rx_frame_err,
  output logic       rx_done,
  output logic       rx_busy
);
  import uart_pkg::*;

  localparam int PH_W     = `UART_OVS_LOG2;
  localparam int OVS_HALF = 1 << (`UART_OVS_LOG2 - 1);

  typedef enum logic [1:0] {
    S_IDLE,
    S_START,
    S_DATA,
    S_STOP
  } rx_state_t;

  rx_state_t       state;
  logic [2:0]      rxd_meta;   // two-flop synchronizer plus edge history
  logic            rxd_s;
  logic            rxd_rise;
  logic [PH_W-1:0] phase_cnt;
  logic [2:0]      bit_idx;
  logic            bit_tick;
  rx_entry_t       rx_word;

  always_ff @(posedge ref_clk) begin
    rxd_meta <= {rxd_meta[1:0], rxd};
  end

  assign rxd_s    = rxd_meta[1];
  assign rxd_rise = rxd_meta[1] && !rxd_meta[2];  // start edge

  // ##################################################
  // bit phase, restarted by the rising start edge
  always_ff @(posedge ref_clk) begin
    if (reset || state == S_IDLE)
      phase_cnt <= '0;
    else if (samp_tick)
      phase_cnt <= phase_cnt + 1'b1;   // wraps every bit period
  end

  assign bit_tick = samp_tick && (phase_cnt == PH_W'(OVS_HALF - 1));  // mid-bit

  // ##################################################
  // frame FSM
  always_ff @(posedge ref_clk) begin
    if (reset) begin
      state   <= S_IDLE;
      bit_idx <= '0;
      rx_done <= 1'b0;
    end else begin
      rx_done <= 1'b0;
      case (state)
        S_IDLE: begin
          bit_idx <= '0;
          if (rxd_rise) state <= S_START;
        end
        S_START: if (bit_tick) state <= rxd_s ? S_DATA : S_IDLE;  // glitch reject
        S_DATA: if (bit_tick) begin
          bit_idx <= bit_idx + 1'b1;
          if (bit_idx == 3'd7) state <= S_STOP;
        end
        S_STOP: if (bit_tick) begin
          rx_done <= 1'b1;
          state   <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge ref_clk) begin
    if (bit_tick && state == S_DATA)
      rx_word.data <= {~rxd_s, rx_word.data[7:1]};  // lsb first, inverted
    if (bit_tick && state == S_STOP)
      rx_word.frame_err <= rxd_s;                   // stop must be low
  end

  assign rx_data      = rx_word.data;
  assign rx_frame_err = rx_word.frame_err;
  assign rx_busy      = (state != S_IDLE);

  a_done_on_tick: assert property (@(posedge ref_clk) disable iff (reset)
    rx_done |-> $past(samp_tick));

endmodule

// ==== hw/rs232_tx.sv ====
/* RS232 transmitter
   sends one 10-bit frame per FIFO entry, high start, low stop */
`timescale 1ns/10ps
`include "uart_cfg.svh"

module rs232_tx (
  input  logic                ref_clk,
  input  logic                reset,
  input  logic                samp_tick,
  input  logic                tx_empty,
  output logic                tx_pop,
  input  uart_pkg::tx_entry_t tx_byte,
  output logic                txd,
  output logic                tx_busy
);

  typedef enum logic {
    S_IDLE,
    S_SEND
  } tx_state_t;

  tx_state_t                 state;
  logic [9:0]                frame;     // stop, inverted data, start
  logic [`UART_OVS_LOG2-1:0] tick_cnt;
  logic [3:0]                bit_cnt;
  logic                      bit_end;

  // pop on a tick so every bit is exactly one full period
  assign tx_pop  = (state == S_IDLE) && !tx_empty && samp_tick;
  assign bit_end = samp_tick && (tick_cnt == '1);
  assign txd     = (state == S_SEND) && frame[0];  // idle low
  assign tx_busy = (state == S_SEND);

  // ##################################################
  // bit and tick counting
  always_ff @(posedge ref_clk) begin
    if (reset) begin
      state    <= S_IDLE;
      tick_cnt <= '0;
      bit_cnt  <= '0;
    end else begin
      case (state)
        S_IDLE: if (tx_pop) begin
          state    <= S_SEND;
          tick_cnt <= '0;
          bit_cnt  <= '0;
        end
        S_SEND: if (samp_tick) begin
          tick_cnt <= tick_cnt + 1'b1;
          if (bit_end) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 4'd9) state <= S_IDLE;  // stop bit done
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // frame shifter
  always_ff @(posedge ref_clk) begin
    if (tx_pop)
      frame <= {1'b0, ~tx_byte.data, 1'b1};
    else if (bit_end)
      frame <= {1'b0, frame[9:1]};
  end

endmodule

// ==== hw/uart_axil_regs.sv ====
/* AXI4-Lite register block
   DATA feeds the tx FIFO and drains the rx FIFO, STAT shows both sides */
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uart_axil_regs (
  input  logic                ref_clk,
  input  logic                reset,
  input  logic [3:0]          awaddr,
  input  logic                awvalid,
  output logic                awready,
  input  logic [31:0]         wdata,
  input  logic                wvalid,
  output logic                wready,
  output uart_pkg::axi_resp_t bresp,
  output logic                bvalid,
  input  logic                bready,
  input  logic [3:0]          araddr,
  input  logic                arvalid,
  output logic                arready,
  output logic [31:0]         rdata,
  output uart_pkg::axi_resp_t rresp,
  output logic                rvalid,
  input  logic                rready,
  input  logic                rx_push_req,
  input  logic                rx_full,
  output logic                rx_pop,
  input  uart_pkg::rx_entry_t rx_head,
  input  logic                rx_empty,
  output logic                tx_push,
  output uart_pkg::tx_entry_t tx_din,
  input  logic                tx_full,
  input  logic                tx_busy
);
  import uart_pkg::*;

  logic        wr_go;
  logic        rd_go;
  logic        wr_data_sel;
  logic        rd_data_sel;
  logic        rd_stat_sel;
  logic        rx_overrun;    // sticky
  axi_resp_t   wr_resp;
  axi_resp_t   rd_resp;
  logic [31:0] rd_word;
  logic [31:0] stat_word;

  // ##################################################
  // write side
  assign wr_go       = awvalid && wvalid && !awready && !bvalid;
  assign wr_data_sel = (awaddr == `UART_ADDR_DATA);
  assign tx_push     = awready && wr_data_sel && !tx_full;  // full drops the byte
  assign tx_din      = tx_entry_t'(wdata[7:0]);

  always_comb begin
    if (wr_data_sel)
      wr_resp = tx_full ? RESP_SLVERR : RESP_OKAY;
    else if (awaddr == `UART_ADDR_STAT)
      wr_resp = RESP_OKAY;      // read-only, write ignored
    else
      wr_resp = RESP_SLVERR;
  end

  // ##################################################
  // read side
  assign rd_go       = arvalid && !arready && !rvalid;
  assign rd_data_sel = (araddr == `UART_ADDR_DATA);
  assign rd_stat_sel = (araddr == `UART_ADDR_STAT);
  assign rx_pop      = arready && rd_data_sel && !rx_empty;
  assign stat_word   = {28'd0, tx_busy, rx_overrun, tx_full, !rx_empty};

  always_comb begin
    rd_word = '0;
    rd_resp = RESP_SLVERR;
    if (rd_data_sel && !rx_empty) begin
      rd_word = {23'd0, rx_head};   // frame_err on bit 8
      rd_resp = RESP_OKAY;
    end else if (rd_stat_sel) begin
      rd_word = stat_word;
      rd_resp = RESP_OKAY;
    end
  end

  // ##################################################
  // handshakes
  always_ff @(posedge ref_clk) begin
    if (reset) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      awready <= wr_go;            // single-cycle pulses
      wready  <= wr_go;
      arready <= rd_go;
      if (awready)
        bvalid <= 1'b1;
      else if (bready)
        bvalid <= 1'b0;
      if (arready)
        rvalid <= 1'b1;
      else if (rready)
        rvalid <= 1'b0;
    end
  end

  always_ff @(posedge ref_clk) begin
    if (awready) bresp <= wr_resp;
    if (arready) begin
      rdata <= rd_word;
      rresp <= rd_resp;
    end
  end

  // a new overrun in the clearing cycle wins
  always_ff @(posedge ref_clk) begin
    if (reset)
      rx_overrun <= 1'b0;
    else if (rx_push_req && rx_full)
      rx_overrun <= 1'b1;
    else if (arready && rd_stat_sel)
      rx_overrun <= 1'b0;
  end

  a_wr_no_overlap: assert property (@(posedge ref_clk) disable iff (reset)
    (awready || wready) |-> !bvalid);

endmodule

// ==== hw/uart_axil_top.sv ====
/* RS232 serial port with AXI4-Lite access
   tick generator, rx/tx engines, both FIFOs and the register block */
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uart_axil_top (
  input  logic                ref_clk,
  input  logic                reset,
  input  logic [3:0]          awaddr,
  input  logic                awvalid,
  output logic                awready,
  input  logic [31:0]         wdata,
  input  logic                wvalid,
  output logic                wready,
  output uart_pkg::axi_resp_t bresp,
  output logic                bvalid,
  input  logic                bready,
  input  logic [3:0]          araddr,
  input  logic                arvalid,
  output logic                arready,
  output logic [31:0]         rdata,
  output uart_pkg::axi_resp_t rresp,
  output logic                rvalid,
  input  logic                rready,
  input  logic                rxd,
  output logic                txd
);
  import uart_pkg::*;

  logic       samp_tick;
  logic [7:0] rx_data;
  logic       rx_frame_err;
  logic       rx_done;
  logic       rx_push;
  logic       rx_full;
  logic       rx_pop;
  logic       rx_empty;
  rx_entry_t  rx_din;
  rx_entry_t  rx_head;
  logic       tx_push;
  logic       tx_full;
  logic       tx_pop;
  logic       tx_empty;
  logic       tx_busy;
  tx_entry_t  tx_din;
  tx_entry_t  tx_byte;

  assign rx_din  = '{frame_err: rx_frame_err, data: rx_data};
  assign rx_push = rx_done && !rx_full;   // frame dropped on overrun

  baud_tick_gen u_baud_tick_gen (
    .ref_clk   (ref_clk),
    .reset     (reset),
    .samp_tick (samp_tick)
  );

  // ##################################################
  // receive path
  rs232_rx u_rs232_rx (
    .ref_clk      (ref_clk),
    .reset        (reset),
    .samp_tick    (samp_tick),
    .rxd          (rxd),
    .rx_data      (rx_data),
    .rx_frame_err (rx_frame_err),
    .rx_done      (rx_done),
    .rx_busy      ()
  );

  byte_fifo #(.entry_t(rx_entry_t), .DEPTH(`UART_RX_DEPTH)) u_rx_fifo (
    .ref_clk (ref_clk),
    .reset   (reset),
    .push    (rx_push),
    .din     (rx_din),
    .full    (rx_full),
    .pop     (rx_pop),
    .dout    (rx_head),
    .empty   (rx_empty)
  );

  // ##################################################
  // transmit path
  byte_fifo #(.entry_t(tx_entry_t), .DEPTH(`UART_TX_DEPTH)) u_tx_fifo (
    .ref_clk (ref_clk),
    .reset   (reset),
    .push    (tx_push),
    .din     (tx_din),
    .full    (tx_full),
    .pop     (tx_pop),
    .dout    (tx_byte),
    .empty   (tx_empty)
  );

  rs232_tx u_rs232_tx (
    .ref_clk   (ref_clk),
    .reset     (reset),
    .samp_tick (samp_tick),
    .tx_empty  (tx_empty),
    .tx_pop    (tx_pop),
    .tx_byte   (tx_byte),
    .txd       (txd),
    .tx_busy   (tx_busy)
  );

  // bus ports and FIFO nets share names with the slave
  uart_axil_regs u_uart_axil_regs (
    .rx_push_req (rx_done),
    .*
  );

endmodule

// ==== hw/uart_cfg.svh ====
/* UART configuration
   tick divisor, oversampling, FIFO depths and register map */
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// ##################################################
// line timing
`define UART_CLK_DIV   4      // ref_clk cycles per sampling tick
`define UART_OVS_LOG2  3      // 2**3 = 8 ticks per bit

// ##################################################
// buffering
`define UART_RX_DEPTH  4
`define UART_TX_DEPTH  4

// ##################################################
// AXI4-Lite register offsets
`define UART_ADDR_DATA 4'h0
`define UART_ADDR_STAT 4'h4

`endif

// ==== hw/uart_pkg.sv ====
/* UART shared types
   FIFO entry layouts and AXI response codes */
package uart_pkg;

  // receive entry, frame_err lands on rdata[8] when read
  typedef struct packed {
    logic       frame_err;  // stop bit sampled high
    logic [7:0] data;
  } rx_entry_t;

  // transmit entry, byte as written to DATA
  typedef struct packed {
    logic [7:0] data;
  } tx_entry_t;

  // only the two codes this slave returns
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_t;

endpackage
